// File: tb.f
design/vdma_pkg.sv
design/fifo_if.sv
design/sync_fifo.sv
design/pixel_packer.sv
design/burst_planner.sv
design/axi_burst_writer.sv
design/vdma_write_top.sv
verif/vdma_write_tb.sv

// File: Makefile
TOP := vdma_write_tb

.PHONY: run build lint clean

run: build
	@out=$$(./obj_dir/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -qx "TESTS PASSED"

build:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f tb.f

lint:
	verilator --lint-only --timing -Wall --top-module vdma_write_top -f tb.f

clean:
	rm -rf obj_dir

// File: verif/vdma_write_tb.sv
`timescale 1ns/1ps
module vdma_write_tb;

    localparam int BURST_LEN   = 16;
    localparam int LINE_STRIDE = 4096;
    localparam int FRAMES      = 3;
    localparam int LINES       = 4;
    localparam int DRAIN_LIMIT = 4000;

    logic                        clock;
    logic                        rst_n;
    vdma_pkg::addr_t             baseaddr;
    logic [vdma_pkg::HACT_W-1:0] hactive;
    logic                        fsync;
    logic                        de;
    vdma_pkg::pixel_t            idata;
    logic                        fifo_almost_full;
    logic                        resp_error;
    vdma_pkg::addr_t             axi_awaddr;
    vdma_pkg::len_t              axi_awlen;
    logic                        axi_awvalid;
    logic                        axi_awready;
    vdma_pkg::beat_t             axi_wdata;
    logic                        axi_wlast;
    logic                        axi_wvalid;
    logic                        axi_wready;
    logic                        axi_bready;
    logic                        axi_bvalid;
    logic [1:0]                  axi_bresp;

    // reference model filled by the stimulus
    vdma_pkg::burst_cmd_t exp_cmd_q[$];
    vdma_pkg::beat_t      exp_beat_q[$];
    vdma_pkg::burst_cmd_t exp_cmd;
    vdma_pkg::beat_t      exp_beat;

    int errors;
    int exp_bursts;
    int exp_beats;
    int aw_count;
    int w_count;
    int b_count;
    int cur_len;
    int beat_idx;
    int err_burst;
    int resp_idx;
    int b_wait;
    bit err_seen;
    bit last_evt;
    bit b_evt;
    bit drained;
    bit timed_out;

    vdma_write_top #(
        .BURST_LEN   (BURST_LEN),
        .LINE_STRIDE (LINE_STRIDE)
    ) dut (
        .clock            (clock),
        .rst_n            (rst_n),
        .baseaddr         (baseaddr),
        .hactive          (hactive),
        .fsync            (fsync),
        .de               (de),
        .idata            (idata),
        .fifo_almost_full (fifo_almost_full),
        .resp_error       (resp_error),
        .axi_awaddr       (axi_awaddr),
        .axi_awlen        (axi_awlen),
        .axi_awvalid      (axi_awvalid),
        .axi_awready      (axi_awready),
        .axi_wdata        (axi_wdata),
        .axi_wlast        (axi_wlast),
        .axi_wvalid       (axi_wvalid),
        .axi_wready       (axi_wready),
        .axi_bready       (axi_bready),
        .axi_bvalid       (axi_bvalid),
        .axi_bresp        (axi_bresp)
    );

    // 4 ns period
    always #2 clock = ~clock;

    // inputs change 1 ns after the rising edge
    task automatic next_cycle();
        @(posedge clock);
        #1;
    endtask

    task automatic expect_low(input string name, input logic got);
        if (got !== 1'b0) begin
            errors++;
            $display("CHECK FAILED %s exp %h got %h", name, 1'b0, got);
        end
    endtask

    // one line of video plus its expected bursts and beats
    task automatic send_line(input vdma_pkg::addr_t line_addr);
        int h;
        int nbeats;
        int covered;
        int chunk;
        vdma_pkg::burst_cmd_t cmd;
        vdma_pkg::beat_t      beat;
        vdma_pkg::pixel_t     pix;
        // multiples of four up to 160 so tails show up often
        h       = $urandom_range(40, 1) * 4;
        nbeats  = h / 4;
        hactive = 16'(h);
        covered = 0;
        while (covered < nbeats) begin
            chunk    = (nbeats - covered > BURST_LEN) ? BURST_LEN : nbeats - covered;
            cmd.addr = line_addr + vdma_pkg::addr_t'(covered * vdma_pkg::BEAT_BYTES);
            cmd.len  = vdma_pkg::len_t'(chunk - 1);
            exp_cmd_q.push_back(cmd);
            exp_bursts++;
            covered += chunk;
        end
        exp_beats += nbeats;
        next_cycle();
        beat = '0;
        for (int i = 0; i < h; i++) begin
            pix   = $urandom();
            de    = 1'b1;
            idata = pix;
            // pixel 0 of each group lands in the low bits
            beat[(i % 4) * vdma_pkg::PIXEL_W +: vdma_pkg::PIXEL_W] = pix;
            if (i % 4 == 3) begin
                exp_beat_q.push_back(beat);
            end
            next_cycle();
        end
        de    = 1'b0;
        idata = '0;
    endtask

    // in the line gap everything queued must reach the bus and get its response
    task automatic drain_writer(output bit ok);
        int cycles;
        cycles = 0;
        ok     = 1'b0;
        while (!ok && cycles < DRAIN_LIMIT) begin
            next_cycle();
            cycles++;
            ok = (exp_cmd_q.size() == 0) && (exp_beat_q.size() == 0) && (b_count == aw_count);
        end
        if (!ok) begin
            errors++;
            $display("timeout, writer did not finish the line within %0d cycles", DRAIN_LIMIT);
        end
    endtask

    // memory side with random stalls and a delayed response
    always @(posedge clock) begin
        #1;
        if (!rst_n) begin
            axi_awready = 1'b0;
            axi_wready  = 1'b0;
            axi_bvalid  = 1'b0;
            axi_bresp   = 2'b00;
            b_wait      = 0;
        end else begin
            axi_awready = ($urandom_range(99, 0) < 70);
            axi_wready  = ($urandom_range(99, 0) < 70);
            if (b_evt) begin
                axi_bvalid = 1'b0;
                axi_bresp  = 2'b00;
            end
            if (last_evt) begin
                b_wait = $urandom_range(4, 1);
            end else if (b_wait > 0) begin
                b_wait--;
                if (b_wait == 0) begin
                    axi_bvalid = 1'b1;
                    // one slverr somewhere in the run
                    axi_bresp  = (resp_idx == err_burst) ? 2'b10 : 2'b00;
                    resp_idx++;
                end
            end
        end
        last_evt = 1'b0;
        b_evt    = 1'b0;
    end

    // monitor at the falling edge where a handshake completes at the next rise
    always @(negedge clock) begin
        if (rst_n) begin
            // sticky error only after the bad response
            if (resp_error !== err_seen) begin
                errors++;
                $display("CHECK FAILED resp_error exp %h got %h", err_seen, resp_error);
            end
            if (axi_awvalid && axi_awready) begin
                aw_count++;
                beat_idx = 0;
                if (exp_cmd_q.size() == 0) begin
                    errors++;
                    $display("burst issued at address %h with none expected", axi_awaddr);
                end else begin
                    exp_cmd = exp_cmd_q.pop_front();
                    cur_len = int'(exp_cmd.len);
                    if (axi_awaddr !== exp_cmd.addr) begin
                        errors++;
                        $display("CHECK FAILED axi_awaddr exp %h got %h",
                                 exp_cmd.addr, axi_awaddr);
                    end
                    if (axi_awlen !== exp_cmd.len) begin
                        errors++;
                        $display("CHECK FAILED axi_awlen exp %h got %h",
                                 exp_cmd.len, axi_awlen);
                    end
                end
            end
            if (axi_wvalid && axi_wready) begin
                w_count++;
                if (exp_beat_q.size() == 0) begin
                    errors++;
                    $display("write beat %h sent with none expected", axi_wdata);
                end else begin
                    exp_beat = exp_beat_q.pop_front();
                    if (axi_wdata !== exp_beat) begin
                        errors++;
                        $display("CHECK FAILED axi_wdata exp %h got %h", exp_beat, axi_wdata);
                    end
                end
                if (axi_wlast !== (beat_idx == cur_len)) begin
                    errors++;
                    $display("CHECK FAILED axi_wlast exp %h got %h",
                             (beat_idx == cur_len), axi_wlast);
                end
                if (axi_wlast) begin
                    last_evt = 1'b1;
                end
                beat_idx++;
            end
            if (axi_bvalid && axi_bready) begin
                b_count++;
                b_evt = 1'b1;
                if (axi_bresp != 2'b00) begin
                    err_seen = 1'b1;
                end
            end
        end
    end

    initial begin
        void'($urandom(32'hd7598f2d));
        clock       = 1'b0;
        rst_n       = 1'b0;
        baseaddr    = '0;
        hactive     = '0;
        fsync       = 1'b0;
        de          = 1'b0;
        idata       = '0;
        axi_awready = 1'b0;
        axi_wready  = 1'b0;
        axi_bvalid  = 1'b0;
        axi_bresp   = 2'b00;
        // at least 12 bursts in the run
        err_burst   = $urandom_range(10, 2);
        timed_out   = 1'b0;

        repeat (16) @(posedge clock);
        #1;
        rst_n = 1'b1;
        repeat (4) next_cycle();

        // idle outputs before any frame
        @(negedge clock);
        expect_low("axi_awvalid", axi_awvalid);
        expect_low("axi_wvalid", axi_wvalid);
        expect_low("axi_wlast", axi_wlast);
        expect_low("axi_bready", axi_bready);
        expect_low("resp_error", resp_error);
        expect_low("fifo_almost_full", fifo_almost_full);
        next_cycle();

        for (int f = 0; f < FRAMES && !timed_out; f++) begin
            baseaddr = $urandom() & 32'hffff_fff0;
            fsync    = 1'b1;
            next_cycle();
            fsync    = 1'b0;
            repeat (2) next_cycle();
            for (int l = 0; l < LINES && !timed_out; l++) begin
                send_line(baseaddr + vdma_pkg::addr_t'(l * LINE_STRIDE));
                drain_writer(drained);
                timed_out = !drained;
                repeat (3) next_cycle();
            end
        end

        if (!timed_out) begin
            // totals show nothing lost or repeated
            if (aw_count != exp_bursts) begin
                errors++;
                $display("CHECK FAILED burst count exp %h got %h", exp_bursts, aw_count);
            end
            if (w_count != exp_beats) begin
                errors++;
                $display("CHECK FAILED beat count exp %h got %h", exp_beats, w_count);
            end
            if (resp_error !== 1'b1) begin
                errors++;
                $display("CHECK FAILED resp_error exp %h got %h", 1'b1, resp_error);
            end
        end

        $display("errors %0d, bursts %0d of %0d, beats %0d of %0d",
                 errors, aw_count, exp_bursts, w_count, exp_beats);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

// File: design/vdma_write_top.sv
`timescale 1ns/1ps
module vdma_write_top #(
    parameter int BURST_LEN       = 16,
    parameter int LINE_STRIDE     = 4096,
    parameter int BEAT_FIFO_DEPTH = 64,
    parameter int CMD_FIFO_DEPTH  = 8
)(
    input  logic                        clock,
    input  logic                        rst_n,
    input  vdma_pkg::addr_t             baseaddr,
    input  logic [vdma_pkg::HACT_W-1:0] hactive,
    input  logic                        fsync,
    input  logic                        de,
    input  vdma_pkg::pixel_t            idata,
    output logic                        fifo_almost_full,
    output logic                        resp_error,
    // axi4 write address
    output vdma_pkg::addr_t             axi_awaddr,
    output vdma_pkg::len_t              axi_awlen,
    output logic                        axi_awvalid,
    input  logic                        axi_awready,
    // axi4 write data
    output vdma_pkg::beat_t             axi_wdata,
    output logic                        axi_wlast,
    output logic                        axi_wvalid,
    input  logic                        axi_wready,
    // axi4 write response
    output logic                        axi_bready,
    input  logic                        axi_bvalid,
    input  logic [1:0]                  axi_bresp
);

    // packer to writer, pixel data
    fifo_if #(.T(vdma_pkg::beat_t))      beat_bus ();
    // planner to writer, burst requests
    fifo_if #(.T(vdma_pkg::burst_cmd_t)) cmd_bus ();

    // warning raised eight entries before full
    assign fifo_almost_full = beat_bus.almost_full;

    pixel_packer u_packer (
        .clock (clock),
        .rst_n (rst_n),
        .fsync (fsync),
        .de    (de),
        .idata (idata),
        .beats (beat_bus.writer)
    );

    sync_fifo #(
        .T               (vdma_pkg::beat_t),
        .DEPTH           (BEAT_FIFO_DEPTH),
        .ALMOST_FULL_GAP (8)
    ) u_beat_fifo (
        .clock (clock),
        .rst_n (rst_n),
        .port  (beat_bus.store)
    );

    burst_planner #(
        .BURST_LEN   (BURST_LEN),
        .LINE_STRIDE (LINE_STRIDE)
    ) u_planner (
        .clock    (clock),
        .rst_n    (rst_n),
        .fsync    (fsync),
        .de       (de),
        .baseaddr (baseaddr),
        .hactive  (hactive),
        .cmds     (cmd_bus.writer)
    );

    sync_fifo #(
        .T               (vdma_pkg::burst_cmd_t),
        .DEPTH           (CMD_FIFO_DEPTH),
        .ALMOST_FULL_GAP (2)
    ) u_cmd_fifo (
        .clock (clock),
        .rst_n (rst_n),
        .port  (cmd_bus.store)
    );

    axi_burst_writer #(
        .BURST_LEN (BURST_LEN)
    ) u_writer (
        .clock       (clock),
        .rst_n       (rst_n),
        .beats       (beat_bus.reader),
        .cmds        (cmd_bus.reader),
        .axi_awaddr  (axi_awaddr),
        .axi_awlen   (axi_awlen),
        .axi_awvalid (axi_awvalid),
        .axi_awready (axi_awready),
        .axi_wdata   (axi_wdata),
        .axi_wlast   (axi_wlast),
        .axi_wvalid  (axi_wvalid),
        .axi_wready  (axi_wready),
        .axi_bready  (axi_bready),
        .axi_bvalid  (axi_bvalid),
        .axi_bresp   (axi_bresp),
        .resp_error  (resp_error)
    );

endmodule

// File: design/axi_burst_writer.sv
`timescale 1ns/1ps
module axi_burst_writer #(
    parameter int BURST_LEN = 16
)(
    input  logic             clock,
    input  logic             rst_n,
    fifo_if.reader           beats,
    fifo_if.reader           cmds,
    output vdma_pkg::addr_t  axi_awaddr,
    output vdma_pkg::len_t   axi_awlen,
    output logic             axi_awvalid,
    input  logic             axi_awready,
    output vdma_pkg::beat_t  axi_wdata,
    output logic             axi_wlast,
    output logic             axi_wvalid,
    input  logic             axi_wready,
    output logic             axi_bready,
    input  logic             axi_bvalid,
    input  logic [1:0]       axi_bresp,
    output logic             resp_error
);

    typedef enum logic [1:0] {
        S_IDLE,
        S_ADDR,
        S_DATA,
        S_RESP
    } state_t;

    state_t         state;
    // beats sent in the current burst
    vdma_pkg::len_t beat_cnt;
    logic           aw_hs;
    logic           w_hs;
    logic           b_hs;

    assign aw_hs = axi_awvalid && axi_awready;
    assign w_hs  = axi_wvalid && axi_wready;
    assign b_hs  = axi_bvalid && axi_bready;

    // take a command only between bursts
    assign cmds.pop    = (state == S_IDLE) && !cmds.empty;

    assign axi_awvalid = (state == S_ADDR);
    // W follows whatever the packer has buffered
    assign axi_wvalid  = (state == S_DATA) && !beats.empty;
    assign axi_wdata   = beats.pop_data;
    assign axi_wlast   = (state == S_DATA) && (beat_cnt == axi_awlen);
    assign axi_bready  = (state == S_RESP);
    // one beat leaves the fifo per W handshake
    assign beats.pop   = w_hs;

    // address and length held for the whole burst
    always_ff @(posedge clock) begin
        if (cmds.pop) begin
            axi_awaddr <= cmds.pop_data.addr;
            axi_awlen  <= cmds.pop_data.len;
        end
    end

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            state    <= S_IDLE;
            beat_cnt <= '0;
        end else begin
            case (state)
                S_IDLE: begin
                    if (cmds.pop) begin
                        state <= S_ADDR;
                    end
                end
                S_ADDR: begin
                    beat_cnt <= '0;
                    if (aw_hs) begin
                        state <= S_DATA;
                    end
                end
                S_DATA: begin
                    if (w_hs) begin
                        beat_cnt <= beat_cnt + 1'b1;
                        if (axi_wlast) begin
                            state <= S_RESP;
                        end
                    end
                end
                // wait out the write response
                default: begin
                    if (b_hs) begin
                        state <= S_IDLE;
                    end
                end
            endcase
        end
    end

    // any slverr or decerr sticks until reset
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            resp_error <= 1'b0;
        end else if (b_hs && (axi_bresp != 2'b00)) begin
            resp_error <= 1'b1;
        end
    end

    // axi4 forbids withdrawal or change before awready
    aw_stable: assert property (
        @(posedge clock) disable iff (!rst_n)
        axi_awvalid && !axi_awready |=> axi_awvalid && $stable(axi_awaddr)
                                       && $stable(axi_awlen)
    ) else $error("aw channel changed while stalled");

    // planner never asks for more than one full burst
    aw_len_max: assert property (
        @(posedge clock) disable iff (!rst_n)
        axi_awvalid |-> (axi_awlen <= vdma_pkg::len_t'(BURST_LEN - 1))
    ) else $error("burst longer than BURST_LEN");

    no_beat_underflow: assert property (
        @(posedge clock) disable iff (!rst_n)
        beats.pop |-> !beats.empty
    ) else $error("pop from empty beat fifo");

    no_cmd_underflow: assert property (
        @(posedge clock) disable iff (!rst_n)
        cmds.pop |-> !cmds.empty
    ) else $error("pop from empty command fifo");

endmodule

// File: design/burst_planner.sv
`timescale 1ns/1ps
module burst_planner #(
    parameter int BURST_LEN   = 16,
    parameter int LINE_STRIDE = 4096
)(
    input  logic                       clock,
    input  logic                       rst_n,
    input  logic                       fsync,
    input  logic                       de,
    input  vdma_pkg::addr_t            baseaddr,
    input  logic [vdma_pkg::HACT_W-1:0] hactive,
    fifo_if.writer                     cmds
);

    // beats per line, hactive over four
    localparam int BEATS_W = vdma_pkg::HACT_W - 2;

    logic                de_q;
    logic                de_rise;
    // still emitting commands for this line
    logic                busy;
    logic [BEATS_W-1:0]  remaining;
    logic [BEATS_W-1:0]  covered;
    logic [BEATS_W-1:0]  chunk;
    logic [BEATS_W-1:0]  line_beats;
    vdma_pkg::addr_t     line_base;
    vdma_pkg::burst_cmd_t cmd;

    assign de_rise    = de && !de_q;
    assign line_beats = hactive[vdma_pkg::HACT_W-1:2];

    // full burst, or whatever is left as the tail
    assign chunk = (remaining > BEATS_W'(BURST_LEN)) ? BEATS_W'(BURST_LEN) : remaining;

    always_comb begin
        cmd.addr = line_base
                 + vdma_pkg::addr_t'(covered) * vdma_pkg::addr_t'(vdma_pkg::BEAT_BYTES);
        cmd.len  = vdma_pkg::len_t'(chunk - 1'b1);
    end

    // one command per cycle while busy
    assign cmds.push      = busy;
    assign cmds.push_data = cmd;

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            de_q      <= 1'b0;
            busy      <= 1'b0;
            remaining <= '0;
            covered   <= '0;
            line_base <= '0;
        end else begin
            de_q <= de;
            // new frame restarts at the base address
            if (fsync) begin
                line_base <= baseaddr;
            end
            if (de_rise) begin
                remaining <= line_beats;
                covered   <= '0;
                // empty line, nothing to plan
                busy      <= (line_beats != '0);
            end else if (busy) begin
                remaining <= remaining - chunk;
                covered   <= covered + chunk;
                // last command of the line goes out now
                if (remaining == chunk) begin
                    busy      <= 1'b0;
                    line_base <= line_base + vdma_pkg::addr_t'(LINE_STRIDE);
                end
            end
        end
    end

    // packer groups pixels in fours with no per line flush
    hact_aligned: assert property (
        @(posedge clock) disable iff (!rst_n)
        de_rise |-> (hactive[1:0] == 2'b00)
    ) else $error("hactive not a multiple of four");

    // writer must keep up with the line rate
    no_cmd_overflow: assert property (
        @(posedge clock) disable iff (!rst_n)
        cmds.push |-> !cmds.full
    ) else $error("command fifo overflow");

endmodule

// File: design/pixel_packer.sv
`timescale 1ns/1ps
module pixel_packer (
    input  logic            clock,
    input  logic            rst_n,
    input  logic            fsync,
    input  logic            de,
    input  vdma_pkg::pixel_t idata,
    fifo_if.writer          beats
);

    localparam int CNT_W = $clog2(vdma_pkg::PIX_PER_BEAT);

    // pixel slot within the current beat
    logic [CNT_W-1:0] pix_cnt;
    logic             beat_done;
    logic             push_q;
    vdma_pkg::beat_t  beat_q;

    // fourth pixel of a beat being sampled now
    assign beat_done = de && (pix_cnt == CNT_W'(vdma_pkg::PIX_PER_BEAT - 1));

    // shift right, newest pixel enters at the top
    // so after four pixels pixel 0 sits in the low bits
    always_ff @(posedge clock) begin
        if (de) begin
            beat_q <= {idata, beat_q[vdma_pkg::BEAT_W-1:vdma_pkg::PIXEL_W]};
        end
    end

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            pix_cnt <= '0;
            push_q  <= 1'b0;
        end else begin
            // frame start realigns the packing
            if (fsync) begin
                pix_cnt <= '0;
            end else if (de) begin
                pix_cnt <= pix_cnt + 1'b1;
            end
            // push lands one cycle after the fourth pixel
            push_q <= beat_done && !fsync;
        end
    end

    assign beats.push      = push_q;
    // beat_q only changes at the edge that takes the push
    assign beats.push_data = beat_q;

    // video cannot stall, so a full fifo here means lost pixels
    no_overflow: assert property (
        @(posedge clock) disable iff (!rst_n)
        beats.push |-> !beats.full
    ) else $error("beat fifo overflow");

endmodule

// File: design/sync_fifo.sv
`timescale 1ns/1ps
module sync_fifo #(
    parameter type T               = logic,
    parameter int  DEPTH           = 8,
    parameter int  ALMOST_FULL_GAP = 2
)(
    input  logic   clock,
    input  logic   rst_n,
    fifo_if.store  port
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    // payload storage
    T mem [DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    // occupancy drives all the flags
    logic [CNT_W-1:0] count;

    always_ff @(posedge clock) begin
        if (port.push) begin
            mem[wr_ptr] <= port.push_data;
        end
    end

    // pointers wrap at DEPTH even for a depth that is not a power of two
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (port.push) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (port.pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            count <= '0;
        end else begin
            case ({port.push, port.pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    assign port.empty       = (count == '0);
    assign port.full        = (count == CNT_W'(DEPTH));
    assign port.almost_full = (count >= CNT_W'(DEPTH - ALMOST_FULL_GAP));

    // first word fall through
    // head visible one cycle after its push
    assign port.pop_data    = mem[rd_ptr];

endmodule

// File: design/fifo_if.sv
`timescale 1ns/1ps
interface fifo_if #(
    parameter type T = logic
);

    // write side
    logic push;
    T     push_data;
    logic full;
    // early warning, threshold set by the fifo
    logic almost_full;

    // read side, head shown while not empty
    logic pop;
    T     pop_data;
    logic empty;

    modport writer (
        output push,
        output push_data,
        input  full,
        input  almost_full
    );

    modport reader (
        output pop,
        input  pop_data,
        input  empty
    );

    // fifo itself
    modport store (
        input  push,
        input  push_data,
        output full,
        output almost_full,
        input  pop,
        output pop_data,
        output empty
    );

endinterface

// File: design/vdma_pkg.sv
package vdma_pkg;

    // one pixel as it comes off the video port
    parameter int PIXEL_W      = 32;
    // four pixels share one memory beat
    parameter int PIX_PER_BEAT = 4;
    parameter int BEAT_W       = PIXEL_W * PIX_PER_BEAT;
    parameter int BEAT_BYTES   = BEAT_W / 8;

    // byte address on the memory side
    parameter int ADDR_W       = 32;
    // axi4 awlen field
    parameter int LEN_W        = 8;
    // active pixels per line
    parameter int HACT_W       = 16;

    typedef logic [PIXEL_W-1:0] pixel_t;
    typedef logic [BEAT_W-1:0]  beat_t;
    typedef logic [ADDR_W-1:0]  addr_t;
    typedef logic [LEN_W-1:0]   len_t;

    // one burst request, planner to writer
    // len is in axi form, beats minus one
    typedef struct packed {
        addr_t addr;
        len_t  len;
    } burst_cmd_t;

endpackage
